/* bench/hub_sva.sv */
/* Hub host protocol assertions
   Busy after reset, no request while busy, bounded answer time */

`timescale 1ns/1ns
`default_nettype none

`include "hub_defines.svh"

module hub_sva (
  input wire sys_clk,
  input wire sys_rst,
  input wire host_req_i,
  input wire host_busy_o,
  input wire host_done_o
);

  localparam int DONE_MAX = 2 * `HUB_SRAM_HOLD + 2;   // Slowest target is SRAM

  int fail_cnt = 0;   // Assertion failures so far

  // ------------------------------
  a_busy_after_reset: assert property (@(posedge sys_clk)
    $fell(sys_rst) |-> !host_busy_o)
  else
  begin
    $error("host_busy_o high right after reset");
    fail_cnt++;
  end

  a_no_req_when_busy: assert property (@(posedge sys_clk) disable iff (sys_rst)
    host_req_i |-> !host_busy_o)
  else
  begin
    $error("host_req_i arrived while host_busy_o was high");
    fail_cnt++;
  end

  a_done_in_time: assert property (@(posedge sys_clk) disable iff (sys_rst)
    (host_req_i && !host_busy_o) |-> ##[1:DONE_MAX] host_done_o)
  else
  begin
    $error("accepted request got no host_done_o in time");
    fail_cnt++;
  end

endmodule

bind hub_top hub_sva u_sva (
  .sys_clk     (sys_clk),
  .sys_rst     (sys_rst),
  .host_req_i  (host_req_i),
  .host_busy_o (host_busy_o),
  .host_done_o (host_done_o)
);

`default_nettype wire

/* bench/hub_tb.sv */
/* Hub testbench
   Runs host requests from the test file against the hub and checks answers and pads */

`timescale 1ns/1ns
`default_nettype none

`include "hub_defines.svh"

module hub_tb;

  localparam int MAX_TESTS = 64;

  typedef logic [3:0][6:0] seg_t;   // hex3 down to hex0
  typedef logic [17:0]     led_t;   // ledr above ledg

  logic                     sys_clk;
  logic                     sys_rst;
  logic                     host_req_i;
  logic                     host_we_i;
  hub_pkg::addr_t           host_addr_i;
  hub_pkg::word_t           host_wdata_i;
  hub_pkg::sel_t            host_sel_i;
  wire                      host_done_o;
  wire                      host_err_o;
  wire hub_pkg::word_t      host_rdata_o;
  wire                      host_busy_o;
  logic [3:0]               key_i;
  logic [9:0]               sw_i;
  wire  [6:0]               hex0_o;
  wire  [6:0]               hex1_o;
  wire  [6:0]               hex2_o;
  wire  [6:0]               hex3_o;
  wire  [7:0]               ledg_o;
  wire  [9:0]               ledr_o;
  wire  [`HUB_SRAM_AW-1:0]  sram_addr_o;
  wire  [`HUB_SRAM_DW-1:0]  sram_dq_io;
  wire                      sram_ce_n_o;
  wire                      sram_oe_n_o;
  wire                      sram_we_n_o;
  wire                      sram_ub_n_o;
  wire                      sram_lb_n_o;

  // Test table, one entry per file line
  logic            t_op    [MAX_TESTS];   // 1 = write
  hub_pkg::addr_t  t_addr  [MAX_TESTS];
  hub_pkg::word_t  t_wdata [MAX_TESTS];
  hub_pkg::sel_t   t_sel   [MAX_TESTS];
  logic [3:0]      t_key   [MAX_TESTS];
  logic [9:0]      t_sw    [MAX_TESTS];
  hub_pkg::word_t  t_rdata [MAX_TESTS];
  logic            t_err   [MAX_TESTS];
  logic [1:0]      t_chk   [MAX_TESTS];   // Bit 0 digits, bit 1 LEDs
  hub_pkg::word_t  t_seg   [MAX_TESTS];   // One byte per digit
  led_t            t_led   [MAX_TESTS];

  int              n_tests     = 0;
  int              error_count = 0;
  int              fail_tests  = 0;
  int              cycle_cnt   = 0;
  int              cycle_limit = 50;
  logic            test_ok;
  logic [15:0]     lfsr_q;

  // ------------------------------
  // DUT and SRAM
  hub_top dut (
    .sys_clk (sys_clk), .sys_rst (sys_rst),
    .host_req_i (host_req_i), .host_we_i (host_we_i), .host_addr_i (host_addr_i),
    .host_wdata_i (host_wdata_i), .host_sel_i (host_sel_i),
    .host_done_o (host_done_o), .host_err_o (host_err_o),
    .host_rdata_o (host_rdata_o), .host_busy_o (host_busy_o),
    .key_i (key_i), .sw_i (sw_i),
    .hex0_o (hex0_o), .hex1_o (hex1_o), .hex2_o (hex2_o), .hex3_o (hex3_o),
    .ledg_o (ledg_o), .ledr_o (ledr_o),
    .sram_addr_o (sram_addr_o), .sram_dq_io (sram_dq_io),
    .sram_ce_n_o (sram_ce_n_o), .sram_oe_n_o (sram_oe_n_o), .sram_we_n_o (sram_we_n_o),
    .sram_ub_n_o (sram_ub_n_o), .sram_lb_n_o (sram_lb_n_o)
  );

  sram_model u_mem (
    .addr_i (sram_addr_o), .dq_io (sram_dq_io), .ce_n_i (sram_ce_n_o),
    .oe_n_i (sram_oe_n_o), .we_n_i (sram_we_n_o), .ub_n_i (sram_ub_n_o),
    .lb_n_i (sram_lb_n_o)
  );

  initial
  begin
    sys_clk = 1'b0;
    forever #10 sys_clk = ~sys_clk;   // 20 ns period
  end

  // Run limit
  always @(posedge sys_clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit)
    begin
      $display("Timeout after %0d cycles, DUT never finished the tests", cycle_cnt);
      $display("Simulation failed");
      $finish;
    end
  end

  // ------------------------------
  // Helpers
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];   // x^16 + x^14 + x^13 + x^11 + 1
    return {s[14:0], fb};
  endfunction

  // Digit n sits in bits 8n+6..8n of the display pads
  function automatic seg_t seg_from_word(input hub_pkg::word_t w);
    seg_t s;
    for (int n = 0; n < 4; n++)
      s[n] = w[8*n +: 7];
    return s;
  endfunction

  task automatic check_word(input string name, input hub_pkg::word_t got,
                            input hub_pkg::word_t exp);
    if (got !== exp)
    begin
      $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      error_count++;
      test_ok = 1'b0;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("CHECK FAILED at %0t ns: %s is %b, expected %b", $time, name, got, exp);
      error_count++;
      test_ok = 1'b0;
    end
  endtask

  task automatic check_seg(input seg_t got, input seg_t exp);
    if (got !== exp)
    begin
      $display("CHECK FAILED at %0t ns: hex3_o..hex0_o is %h, expected %h",
               $time, got, exp);
      error_count++;
      test_ok = 1'b0;
    end
  endtask

  task automatic check_led(input led_t got, input led_t exp);
    if (got !== exp)
    begin
      $display("CHECK FAILED at %0t ns: {ledr_o, ledg_o} is %h, expected %h",
               $time, got, exp);
      error_count++;
      test_ok = 1'b0;
    end
  endtask

  // ------------------------------
  // Test file
  task automatic load_tests();
    int          fd;
    int          rc;
    string       line;
    logic [31:0] col [11];
    fd = $fopen("bench/hub_tests.txt", "r");
    if (fd == 0)
    begin
      $display("ERROR: cannot open bench/hub_tests.txt");
      error_count++;
    end
    else
    begin
      while (!$feof(fd))
      begin
        rc = $fgets(line, fd);
        if (rc > 1 && line.getc(0) != "#")   // Skip blanks and comments
        begin
          rc = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", col[0], col[1], col[2],
                       col[3], col[4], col[5], col[6], col[7], col[8], col[9], col[10]);
          if (rc != 11 || n_tests >= MAX_TESTS)
          begin
            $display("ERROR: test line not usable: %s", line);
            error_count++;
          end
          else
          begin
            t_op[n_tests]    = col[0][0];
            t_addr[n_tests]  = col[1][`HUB_AW-1:0];
            t_wdata[n_tests] = col[2];
            t_sel[n_tests]   = col[3][`HUB_SEL_W-1:0];
            t_key[n_tests]   = col[4][3:0];
            t_sw[n_tests]    = col[5][9:0];
            t_rdata[n_tests] = col[6];
            t_err[n_tests]   = col[7][0];
            t_chk[n_tests]   = col[8][1:0];
            t_seg[n_tests]   = col[9];
            t_led[n_tests]   = col[10][17:0];
            n_tests++;
          end
        end
      end
      $fclose(fd);
    end
    if (n_tests == 0)
    begin
      $display("ERROR: no tests were loaded");
      error_count++;
    end
  endtask

  // One request, wait for done, then compare
  task automatic run_test(input int idx);
    logic [1:0]     gap;
    hub_pkg::word_t rdata_got;
    logic           err_got;
    test_ok = 1'b1;
    if (t_key[idx] !== key_i || t_sw[idx] !== sw_i)
    begin
      key_i = t_key[idx];
      sw_i  = t_sw[idx];
      repeat (3) @(negedge sys_clk);   // Through the input synchronizer
    end
    lfsr_q = lfsr_step(lfsr_q);
    gap[0] = lfsr_q[0];
    lfsr_q = lfsr_step(lfsr_q);
    gap[1] = lfsr_q[0];
    repeat (gap) @(negedge sys_clk);   // Idle 0 to 3 cycles

    host_req_i   = 1'b1;
    host_we_i    = t_op[idx];
    host_addr_i  = t_addr[idx];
    host_wdata_i = t_wdata[idx];
    host_sel_i   = t_sel[idx];
    @(negedge sys_clk);
    host_req_i = 1'b0;
    while (host_done_o !== 1'b1)   // Timeout block ends a hang
      @(negedge sys_clk);
    rdata_got = host_rdata_o;
    err_got   = host_err_o;

    check_bit("host_err_o", err_got, t_err[idx]);
    check_bit("host_busy_o", host_busy_o, 1'b1);   // Held through the done cycle
    if (!t_op[idx])
      check_word("host_rdata_o", rdata_got, t_rdata[idx]);
    if (t_chk[idx][0])
      check_seg({hex3_o, hex2_o, hex1_o, hex0_o}, seg_from_word(t_seg[idx]));
    if (t_chk[idx][1])
      check_led({ledr_o, ledg_o}, t_led[idx]);
    @(negedge sys_clk);
    check_bit("host_busy_o", host_busy_o, 1'b0);   // Idle again after done

    if (!test_ok)
      fail_tests++;
    $display("Test %0d %s addr %05h: %s", idx, t_op[idx] ? "write" : "read",
             t_addr[idx], test_ok ? "ok" : "FAILED");
  endtask

  // ------------------------------
  // Main sequence
  initial
  begin
    sys_rst      = 1'b1;
    host_req_i   = 1'b0;
    host_we_i    = 1'b0;
    host_addr_i  = '0;
    host_wdata_i = '0;
    host_sel_i   = '0;
    key_i        = '0;
    sw_i         = '0;
    lfsr_q       = 16'd19561;
    load_tests();
    cycle_limit = n_tests * 12 + 50;
    repeat (2) @(negedge sys_clk);
    sys_rst = 1'b0;
    for (int i = 0; i < n_tests; i++)
      run_test(i);
    error_count = error_count + dut.u_sva.fail_cnt;   // Protocol assertion failures
    $display("Summary: %0d tests, %0d passed, %0d failed, %0d check errors",
             n_tests, n_tests - fail_tests, fail_tests, error_count);
    if (error_count == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

/* bench/hub_tests.txt */
# op(1=write) addr wdata sel key sw exp_rdata exp_err chk(b0 hex,b1 led) exp_seg exp_led
# all hex; exp_seg holds one byte per digit, exp_led is {ledr, ledg}
0 40000 00000000 f 0 000 00000000 0 3 00000000 00000
1 00010 12345678 f 0 000 00000000 0 0 00000000 00000
1 00011 9abcdef0 f 0 000 00000000 0 0 00000000 00000
0 00010 00000000 f 0 000 12345678 0 0 00000000 00000
0 00011 00000000 f 0 000 9abcdef0 0 0 00000000 00000
1 1fff0 deadbeef f 0 000 00000000 0 0 00000000 00000
0 1fff0 00000000 f 0 000 deadbeef 0 0 00000000 00000
0 00010 00000000 f 0 000 12345678 0 0 00000000 00000
1 00010 0000cafe 3 0 000 00000000 0 0 00000000 00000
0 00010 00000000 f 0 000 1234cafe 0 0 00000000 00000
0 00011 00000000 f 0 000 9abcdef0 0 0 00000000 00000
1 00011 55550000 c 0 000 00000000 0 0 00000000 00000
0 00011 00000000 f 0 000 5555def0 0 0 00000000 00000
1 00011 000000ab 1 0 000 00000000 0 0 00000000 00000
0 00011 00000000 f 0 000 5555deab 0 0 00000000 00000
1 40000 7f3f065b f 0 000 00000000 0 1 00000000 00000
1 40001 ffffffff f 0 000 00000000 0 1 7f3f065b 00000
1 40001 00ff00ff f 0 000 00000000 0 1 003f005b 00000
1 40001 0000ff00 2 0 000 00000000 0 1 003f065b 00000
1 40000 00001200 2 0 000 00000000 0 1 003f125b 00000
0 40000 00000000 f 0 000 7f3f125b 0 1 003f125b 00000
0 40001 00000000 f 0 000 00ffffff 0 0 00000000 00000
0 40002 00000000 f 0 2b6 000002b6 0 0 00000000 00000
1 40002 ffffffff f 0 2b6 00000000 0 1 003f125b 00000
0 40002 00000000 f 0 2b6 000002b6 0 0 00000000 00000
0 40003 00000000 f 0 2b6 00000000 0 0 00000000 00000
1 80001 0003ffff f 0 2b6 00000000 0 2 00000000 00000
1 80000 0002a5c3 f 5 2b6 00000000 0 2 00000000 2a5c3
0 80002 00000000 f 5 2b6 00000005 0 0 00000000 00000
1 80000 ff000000 8 5 2b6 00000000 0 2 00000000 2a5c3
1 80000 00000011 1 5 2b6 00000000 0 2 00000000 2a511
0 80000 00000000 f 5 2b6 ff02a511 0 0 00000000 00000
0 80002 00000000 f a 2b6 0000000a 0 0 00000000 00000
1 80001 00000300 2 a 2b6 00000000 0 2 00000000 20111
0 c0000 00000000 f a 2b6 00000000 1 0 00000000 00000
1 c0010 ffffffff f a 2b6 00000000 1 0 00000000 00000
0 fffff 00000000 f a 2b6 00000000 1 0 00000000 00000
0 1fff0 00000000 f a 2b6 deadbeef 0 3 003f125b 20111

/* bench/sram_model.sv */
/* Async SRAM model
   16-bit words with byte lanes, level-sensitive read and write */

`timescale 1ns/1ns
`default_nettype none

`include "hub_defines.svh"

module sram_model (
  input  wire [`HUB_SRAM_AW-1:0]  addr_i,
  inout  wire [`HUB_SRAM_DW-1:0]  dq_io,
  input  wire                     ce_n_i,
  input  wire                     oe_n_i,
  input  wire                     we_n_i,
  input  wire                     ub_n_i,
  input  wire                     lb_n_i
);

  logic [`HUB_SRAM_DW-1:0] mem [0:(1 << `HUB_SRAM_AW)-1];
  logic                    rd_en;

  assign rd_en        = !ce_n_i && !oe_n_i && we_n_i;
  assign dq_io[7:0]   = (rd_en && !lb_n_i) ? mem[addr_i][7:0]  : 8'bz;   // Low lane
  assign dq_io[15:8]  = (rd_en && !ub_n_i) ? mem[addr_i][15:8] : 8'bz;

  // Write lands 1 ns after the pins move
  always @(addr_i or dq_io or ce_n_i or we_n_i or ub_n_i or lb_n_i)
  begin
    #1;
    if (!ce_n_i && !we_n_i)
    begin
      if (!lb_n_i)
        mem[addr_i][7:0] = dq_io[7:0];
      if (!ub_n_i)
        mem[addr_i][15:8] = dq_io[15:8];
    end
  end

endmodule

`default_nettype wire

/* design/gpio_bank.sv */
/* GPIO bank
   Output and enable registers with byte writes, synchronized input register */

`timescale 1ns/1ns
`default_nettype none

`include "hub_defines.svh"

module gpio_bank #(
  parameter int IN_W = 10   // Input pins
) (
  input  wire                  sys_clk,
  input  wire                  sys_rst,
  hub_bus_if.target            bus,
  input  wire [IN_W-1:0]       pad_in_i,
  output hub_pkg::word_t       pad_o
);

  hub_pkg::word_t              out_q;
  hub_pkg::word_t              oe_q;
  logic [IN_W-1:0]             in_meta_q;   // First sync stage
  logic [IN_W-1:0]             in_q;
  hub_pkg::word_t              in_ext;
  hub_pkg::word_t              rdata_q;
  logic                        ack_q;
  logic [`HUB_GPIO_OFF_W-1:0]  off;
  logic                        wr_en;

  // Byte-strobed update of one register
  function automatic hub_pkg::word_t byte_merge(hub_pkg::word_t cur,
                                                hub_pkg::word_t nxt,
                                                hub_pkg::sel_t  sel);
    hub_pkg::word_t res;
    res = cur;
    for (int b = 0; b < `HUB_SEL_W; b++)
    begin
      if (sel[b])
        res[8*b +: 8] = nxt[8*b +: 8];
    end
    return res;
  endfunction

  assign off    = bus.addr[`HUB_GPIO_OFF_W-1:0];
  assign wr_en  = bus.req && bus.we;
  assign in_ext = {{(`HUB_DW-IN_W){1'b0}}, in_q};   // Zero-extended inputs
  assign pad_o  = out_q & oe_q;                     // Disabled pads read 0

  // ------------------------------
  // Registers and input sync
  always_ff @(posedge sys_clk or posedge sys_rst)
  begin
    if (sys_rst)
    begin
      out_q     <= '0;
      oe_q      <= '0;
      in_meta_q <= '0;
      in_q      <= '0;
      ack_q     <= 1'b0;
    end
    else
    begin
      ack_q     <= bus.req;   // Always one cycle
      in_meta_q <= pad_in_i;
      in_q      <= in_meta_q;
      if (wr_en && (off == `HUB_GPIO_REG_OUT))
        out_q <= byte_merge(out_q, bus.wdata, bus.sel);
      if (wr_en && (off == `HUB_GPIO_REG_OE))
        oe_q <= byte_merge(oe_q, bus.wdata, bus.sel);
    end
  end

  // ------------------------------
  // Read mux, IN is read only
  always_ff @(posedge sys_clk)
  begin
    if (bus.req)
    begin
      case (off)
        `HUB_GPIO_REG_OUT: rdata_q <= out_q;
        `HUB_GPIO_REG_OE:  rdata_q <= oe_q;
        `HUB_GPIO_REG_IN:  rdata_q <= in_ext;
        default:           rdata_q <= '0;
      endcase
    end
  end

  assign bus.rdata = rdata_q;
  assign bus.ack   = ack_q;

endmodule

`default_nettype wire

/* design/hub_bus_if.sv */
/* Hub target bus
   One request from the controller and the target's answer */

`timescale 1ns/1ns
`default_nettype none

interface hub_bus_if;

  // Request side
  logic           req;     // One-cycle strobe
  logic           we;
  hub_pkg::addr_t addr;
  hub_pkg::word_t wdata;
  hub_pkg::sel_t  sel;

  // Answer side
  hub_pkg::word_t rdata;   // Valid with ack
  logic           ack;     // Exactly one per req

  // Controller end
  modport ctrl (
    output req,
    output we,
    output addr,
    output wdata,
    output sel,
    input  rdata,
    input  ack
  );

  // Target end
  modport target (
    input  req,
    input  we,
    input  addr,
    input  wdata,
    input  sel,
    output rdata,
    output ack
  );

endinterface

`default_nettype wire

/* design/hub_ctrl.sv */
/* Hub bus controller
   Decodes host requests to SRAM, display or LED target and returns the answer */

`timescale 1ns/1ns
`default_nettype none

`include "hub_defines.svh"

module hub_ctrl (
  input  wire                  sys_clk,
  input  wire                  sys_rst,
  // Host side
  input  wire                  host_req_i,
  input  wire                  host_we_i,
  input  wire hub_pkg::addr_t  host_addr_i,
  input  wire hub_pkg::word_t  host_wdata_i,
  input  wire hub_pkg::sel_t   host_sel_i,
  output logic                 host_done_o,
  output logic                 host_err_o,
  output hub_pkg::word_t       host_rdata_o,
  output logic                 host_busy_o,
  // Targets
  hub_bus_if.ctrl              bus_sram,
  hub_bus_if.ctrl              bus_disp,
  hub_bus_if.ctrl              bus_led
);

  hub_pkg::ctrl_state_e state_q;
  hub_pkg::region_e     region_q;
  hub_pkg::region_e     host_region;
  logic                 accept;
  logic                 req_q;      // Forwarded strobe
  logic                 err_q;      // Unmapped request finishing
  logic                 we_q;
  hub_pkg::addr_t       addr_q;
  hub_pkg::word_t       wdata_q;
  hub_pkg::sel_t        sel_q;
  logic                 tgt_ack;
  hub_pkg::word_t       tgt_rdata;

  // ------------------------------
  // Accept and decode
  assign host_busy_o = (state_q == hub_pkg::CTRL_WAIT);
  assign accept      = host_req_i && (state_q == hub_pkg::CTRL_IDLE);  // Busy drops strobes
  assign host_region = hub_pkg::region_e'(host_addr_i[`HUB_REGION_MSB:`HUB_REGION_LSB]);

  always_ff @(posedge sys_clk or posedge sys_rst)
  begin
    if (sys_rst)
    begin
      state_q  <= hub_pkg::CTRL_IDLE;
      region_q <= hub_pkg::REGION_NONE;
      req_q    <= 1'b0;
      err_q    <= 1'b0;
    end
    else
    begin
      req_q <= accept && (host_region != hub_pkg::REGION_NONE);
      err_q <= accept && (host_region == hub_pkg::REGION_NONE);
      if (accept)
        region_q <= host_region;
      if (accept)
        state_q <= hub_pkg::CTRL_WAIT;
      else if (host_done_o)
        state_q <= hub_pkg::CTRL_IDLE;   // Back to idle after the answer
    end
  end

  // Request payload, held until the next accept
  always_ff @(posedge sys_clk)
  begin
    if (accept)
    begin
      we_q    <= host_we_i;
      addr_q  <= host_addr_i;
      wdata_q <= host_wdata_i;
      sel_q   <= host_sel_i;
    end
  end

  // ------------------------------
  // Dispatch, strobe only to the selected target
  assign bus_sram.req   = req_q && (region_q == hub_pkg::REGION_SRAM);
  assign bus_sram.we    = we_q;
  assign bus_sram.addr  = addr_q;
  assign bus_sram.wdata = wdata_q;
  assign bus_sram.sel   = sel_q;

  assign bus_disp.req   = req_q && (region_q == hub_pkg::REGION_DISP);
  assign bus_disp.we    = we_q;
  assign bus_disp.addr  = addr_q;
  assign bus_disp.wdata = wdata_q;
  assign bus_disp.sel   = sel_q;

  assign bus_led.req    = req_q && (region_q == hub_pkg::REGION_LED);
  assign bus_led.we     = we_q;
  assign bus_led.addr   = addr_q;
  assign bus_led.wdata  = wdata_q;
  assign bus_led.sel    = sel_q;

  // ------------------------------
  // Answer select
  always_comb
  begin
    tgt_ack   = 1'b0;
    tgt_rdata = '0;   // Unmapped reads as zero
    case (region_q)
      hub_pkg::REGION_SRAM:
      begin
        tgt_ack   = bus_sram.ack;
        tgt_rdata = bus_sram.rdata;
      end
      hub_pkg::REGION_DISP:
      begin
        tgt_ack   = bus_disp.ack;
        tgt_rdata = bus_disp.rdata;
      end
      hub_pkg::REGION_LED:
      begin
        tgt_ack   = bus_led.ack;
        tgt_rdata = bus_led.rdata;
      end
      default:
      begin
        tgt_ack = 1'b0;
      end
    endcase
  end

  assign host_done_o  = host_busy_o && (err_q || tgt_ack);   // Same cycle as ack
  assign host_err_o   = err_q;
  assign host_rdata_o = host_done_o ? tgt_rdata : '0;

endmodule

`default_nettype wire

/* design/hub_defines.svh */
/* Hub shared parameters
   Bus widths, region decode bits, GPIO offsets and SRAM timing */

`ifndef HUB_DEFINES_SVH
`define HUB_DEFINES_SVH

// ------------------------------
// Host bus
`define HUB_DW             32  // Data word
`define HUB_AW             20  // Host word address
`define HUB_SEL_W          4   // One strobe per byte

// Region select in the upper address bits
`define HUB_REGION_MSB     19
`define HUB_REGION_LSB     18

// ------------------------------
// External SRAM
`define HUB_SRAM_AW        18
`define HUB_SRAM_DW        16
`define HUB_SRAM_HOLD      2   // Cycles per half access

// ------------------------------
// GPIO register map, low address bits
`define HUB_GPIO_OFF_W     2
`define HUB_GPIO_REG_OUT   2'd0
`define HUB_GPIO_REG_OE    2'd1
`define HUB_GPIO_REG_IN    2'd2

`endif

/* design/hub_pkg.sv */
/* Hub types
   Bus payload types and the FSM and region enums */

`default_nettype none

`include "hub_defines.svh"

package hub_pkg;

  // ------------------------------
  // Bus payload
  typedef logic [`HUB_DW-1:0]    word_t;
  typedef logic [`HUB_AW-1:0]    addr_t;   // Word address, top 2 bits pick region
  typedef logic [`HUB_SEL_W-1:0] sel_t;

  // Address regions
  typedef enum logic [1:0] {
    REGION_SRAM = 2'd0,
    REGION_DISP = 2'd1,
    REGION_LED  = 2'd2,
    REGION_NONE = 2'd3   // Unmapped, answers with error
  } region_e;

  // ------------------------------
  // FSM states
  typedef enum logic {
    CTRL_IDLE,
    CTRL_WAIT   // Request in flight
  } ctrl_state_e;

  typedef enum logic [1:0] {
    SRAM_IDLE,
    SRAM_LO,    // Low half on the pins
    SRAM_HI     // High half on the pins
  } sram_state_e;

endpackage

`default_nettype wire

/* design/hub_top.sv */
/* Peripheral hub top
   Host bus controller with SRAM port and display and LED GPIO banks on board pins */

`timescale 1ns/1ns
`default_nettype none

`include "hub_defines.svh"

module hub_top (
  input  wire                      sys_clk,
  input  wire                      sys_rst,
  // Host
  input  wire                      host_req_i,
  input  wire                      host_we_i,
  input  wire hub_pkg::addr_t      host_addr_i,
  input  wire hub_pkg::word_t      host_wdata_i,
  input  wire hub_pkg::sel_t       host_sel_i,
  output wire                      host_done_o,
  output wire                      host_err_o,
  output hub_pkg::word_t           host_rdata_o,
  output wire                      host_busy_o,
  // Board inputs
  input  wire [3:0]                key_i,        // Push buttons
  input  wire [9:0]                sw_i,         // Slide switches
  // Seven-segment digits
  output wire [6:0]                hex0_o,
  output wire [6:0]                hex1_o,
  output wire [6:0]                hex2_o,
  output wire [6:0]                hex3_o,
  // LEDs
  output wire [7:0]                ledg_o,
  output wire [9:0]                ledr_o,
  // SRAM
  output wire [`HUB_SRAM_AW-1:0]   sram_addr_o,
  inout  wire [`HUB_SRAM_DW-1:0]   sram_dq_io,
  output wire                      sram_ce_n_o,
  output wire                      sram_oe_n_o,
  output wire                      sram_we_n_o,
  output wire                      sram_ub_n_o,
  output wire                      sram_lb_n_o
);

  hub_bus_if bus_sram ();
  hub_bus_if bus_disp ();
  hub_bus_if bus_led ();

  hub_pkg::word_t disp_pad;
  hub_pkg::word_t led_pad;

  // ------------------------------
  // Controller
  hub_ctrl u_ctrl (
    .sys_clk      (sys_clk),
    .sys_rst      (sys_rst),
    .host_req_i   (host_req_i),
    .host_we_i    (host_we_i),
    .host_addr_i  (host_addr_i),
    .host_wdata_i (host_wdata_i),
    .host_sel_i   (host_sel_i),
    .host_done_o  (host_done_o),
    .host_err_o   (host_err_o),
    .host_rdata_o (host_rdata_o),
    .host_busy_o  (host_busy_o),
    .bus_sram     (bus_sram.ctrl),
    .bus_disp     (bus_disp.ctrl),
    .bus_led      (bus_led.ctrl)
  );

  // ------------------------------
  // Targets
  sram_port u_sram (
    .sys_clk     (sys_clk),
    .sys_rst     (sys_rst),
    .bus         (bus_sram.target),
    .sram_addr_o (sram_addr_o),
    .sram_dq_io  (sram_dq_io),
    .sram_ce_n_o (sram_ce_n_o),
    .sram_oe_n_o (sram_oe_n_o),
    .sram_we_n_o (sram_we_n_o),
    .sram_ub_n_o (sram_ub_n_o),
    .sram_lb_n_o (sram_lb_n_o)
  );

  gpio_bank #(.IN_W(10)) u_disp (   // Reads the switches
    .sys_clk  (sys_clk),
    .sys_rst  (sys_rst),
    .bus      (bus_disp.target),
    .pad_in_i (sw_i),
    .pad_o    (disp_pad)
  );

  gpio_bank #(.IN_W(4)) u_led (     // Reads the buttons
    .sys_clk  (sys_clk),
    .sys_rst  (sys_rst),
    .bus      (bus_led.target),
    .pad_in_i (key_i),
    .pad_o    (led_pad)
  );

  // ------------------------------
  // Pad mapping, one byte per digit
  assign hex0_o = disp_pad[6:0];
  assign hex1_o = disp_pad[14:8];
  assign hex2_o = disp_pad[22:16];
  assign hex3_o = disp_pad[30:24];
  assign ledg_o = led_pad[7:0];
  assign ledr_o = led_pad[17:8];    // Red above green

endmodule

`default_nettype wire

/* design/sram_port.sv */
/* SRAM port
   Runs each 32-bit access as two held 16-bit cycles, low half first */

`timescale 1ns/1ns
`default_nettype none

`include "hub_defines.svh"

module sram_port (
  input  wire                      sys_clk,
  input  wire                      sys_rst,
  hub_bus_if.target                bus,
  // SRAM pins
  output logic [`HUB_SRAM_AW-1:0]  sram_addr_o,
  inout  wire  [`HUB_SRAM_DW-1:0]  sram_dq_io,
  output logic                     sram_ce_n_o,
  output logic                     sram_oe_n_o,
  output logic                     sram_we_n_o,
  output logic                     sram_ub_n_o,
  output logic                     sram_lb_n_o
);

  localparam int HOLD  = `HUB_SRAM_HOLD;
  localparam int CNT_W = (HOLD > 1) ? $clog2(HOLD) : 1;
  localparam int HW    = `HUB_SRAM_DW;   // Half word
  localparam logic [CNT_W-1:0] CNT_LOAD = CNT_W'(HOLD - 1);

  hub_pkg::sram_state_e state_q;
  logic [CNT_W-1:0]     cnt_q;      // Hold cycles left in this half
  logic                 hold_done;
  logic                 drive_q;    // Own the data pins
  logic [HW-1:0]        dq_out_q;
  hub_pkg::word_t       rdata_q;
  logic                 ack_q;

  assign hold_done  = (cnt_q == '0);
  assign sram_dq_io = drive_q ? dq_out_q : 'z;
  assign bus.rdata  = rdata_q;
  assign bus.ack    = ack_q;

  // ------------------------------
  // Half-cycle FSM and strobes
  always_ff @(posedge sys_clk or posedge sys_rst)
  begin
    if (sys_rst)
    begin
      state_q     <= hub_pkg::SRAM_IDLE;
      cnt_q       <= '0;
      sram_ce_n_o <= 1'b1;   // All strobes inactive
      sram_oe_n_o <= 1'b1;
      sram_we_n_o <= 1'b1;
      sram_ub_n_o <= 1'b1;
      sram_lb_n_o <= 1'b1;
      drive_q     <= 1'b0;
      ack_q       <= 1'b0;
    end
    else
    begin
      ack_q <= 1'b0;
      case (state_q)
        hub_pkg::SRAM_IDLE:
        begin
          if (bus.req)
          begin
            state_q     <= hub_pkg::SRAM_LO;
            cnt_q       <= CNT_LOAD;
            sram_ce_n_o <= 1'b0;
            sram_oe_n_o <= bus.we;    // Read drives OE
            sram_we_n_o <= ~bus.we;
            sram_lb_n_o <= ~bus.sel[0];
            sram_ub_n_o <= ~bus.sel[1];
            drive_q     <= bus.we;
          end
        end
        hub_pkg::SRAM_LO:
        begin
          if (hold_done)
          begin
            state_q     <= hub_pkg::SRAM_HI;
            cnt_q       <= CNT_LOAD;
            sram_lb_n_o <= ~bus.sel[2];   // Masks of the upper half
            sram_ub_n_o <= ~bus.sel[3];
          end
          else
            cnt_q <= cnt_q - 1'b1;
        end
        hub_pkg::SRAM_HI:
        begin
          if (hold_done)
          begin
            state_q     <= hub_pkg::SRAM_IDLE;
            sram_ce_n_o <= 1'b1;
            sram_oe_n_o <= 1'b1;
            sram_we_n_o <= 1'b1;
            sram_ub_n_o <= 1'b1;
            sram_lb_n_o <= 1'b1;
            drive_q     <= 1'b0;
            ack_q       <= 1'b1;   // Word complete
          end
          else
            cnt_q <= cnt_q - 1'b1;
        end
        default: state_q <= hub_pkg::SRAM_IDLE;
      endcase
    end
  end

  // ------------------------------
  // Address, write data and read assembly
  always_ff @(posedge sys_clk)
  begin
    case (state_q)
      hub_pkg::SRAM_IDLE:
      begin
        if (bus.req)
        begin
          sram_addr_o <= {bus.addr[`HUB_SRAM_AW-2:0], 1'b0};   // Word w at 2w
          dq_out_q    <= bus.wdata[HW-1:0];
        end
      end
      hub_pkg::SRAM_LO:
      begin
        if (hold_done)
        begin
          if (!bus.we)
            rdata_q[HW-1:0] <= sram_dq_io;   // Last hold cycle
          sram_addr_o[0] <= 1'b1;          // 2w+1
          dq_out_q       <= bus.wdata[2*HW-1:HW];
        end
      end
      hub_pkg::SRAM_HI:
      begin
        if (hold_done && !bus.we)
          rdata_q[2*HW-1:HW] <= sram_dq_io;
      end
    endcase
  end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+design
design/hub_pkg.sv
design/hub_bus_if.sv
design/hub_ctrl.sv
design/sram_port.sv
design/gpio_bank.sv
design/hub_top.sv
bench/sram_model.sv
bench/hub_sva.sv
bench/hub_tb.sv
